// ==== source/netdbg_pkg.sv ====
`default_nettype none

package netdbg_pkg;

	//////////////////////////////////////////////////////////////////////
	// Link word
	//////////////////////////////////////////////////////////////////////
	localparam int P66_W = 66;
	localparam int SYNC_W = 2;

	localparam logic [SYNC_W-1:0] SYNC_CONTROL = 2'b01;
	localparam logic [SYNC_W-1:0] SYNC_DATA = 2'b10;

	// Eight idle characters, block type 1E, control sync
	localparam logic [P66_W-1:0] P_IDLE = {{8{7'h00}}, 8'h1e, SYNC_CONTROL};

	//////////////////////////////////////////////////////////////////////
	// Shared status
	//////////////////////////////////////////////////////////////////////
	localparam int LOCK_W = 2;

	localparam logic [LOCK_W-1:0] LOCK_OK = 2'd0;
	localparam logic [LOCK_W-1:0] LOCK_LOCAL = 2'd1;
	localparam logic [LOCK_W-1:0] LOCK_REMOTE = 2'd2;
	localparam logic [LOCK_W-1:0] LOCK_PHY = 2'd3;

	localparam int TIME_W = 8;
	localparam int PKTLEN_W = 18;

	//////////////////////////////////////////////////////////////////////
	// Records
	//////////////////////////////////////////////////////////////////////
	localparam int KIND_W = 3;

	localparam logic [KIND_W-1:0] KIND_IDLE = 3'd0;
	localparam logic [KIND_W-1:0] KIND_RX = 3'd4;
	localparam logic [KIND_W-1:0] KIND_CRC = 3'd5;
	localparam logic [KIND_W-1:0] KIND_TX = 3'd6;
	localparam logic [KIND_W-1:0] KIND_TXGATE = 3'd7;

	// Idle run length is 2**LGIDLE words
	localparam int LGIDLE = 12;
	localparam int RPT_W = 16;

	localparam int N_SRC = 5;
	localparam int SRC_IDX_W = 3;
	localparam int DBG_W = 31;

	typedef struct packed {
		logic [LOCK_W-1:0] lock;
		logic [KIND_W-1:0] kind;
		logic [TIME_W-3:0] time_hi;
		logic [PKTLEN_W-1:0] pktlen;
		logic [SYNC_W-1:0] sync;
	} stat_rec_t;

	typedef struct packed {
		logic [LOCK_W-1:0] lock;
		logic [KIND_W-1:0] kind;
		logic [TIME_W-1:0] stamp;
		logic [RPT_W-1:0] count;
		logic [SYNC_W-1:0] sync;
	} idle_rec_t;

	// Same 31-bit word, two decodings selected by kind
	typedef union packed {
		stat_rec_t stat_rec;
		idle_rec_t idle_rec;
	} dbg_word_u;

endpackage

`default_nettype wire

// ==== source/netdbg_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module netdbg_status (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_phy_fault,
	input wire logic i_remote_fault,
	input wire logic i_local_fault,
	input wire logic i_p66b_valid,
	input wire logic [netdbg_pkg::SYNC_W-1:0] i_p66b_data,
	output logic [netdbg_pkg::LOCK_W-1:0] o_lock,
	output logic o_phy_fault,
	output logic [netdbg_pkg::TIME_W-1:0] o_time,
	output logic o_tick,
	output logic [netdbg_pkg::SYNC_W-1:0] o_sync
);

	logic [2:0] fault_pipe;
	logic [netdbg_pkg::SYNC_W-1:0] last_sync;

	// Three-flop synchroniser, assume a fault until the pipe fills
	always_ff @(posedge i_clk)
		if (i_reset)
			fault_pipe <= '1;
		else
			fault_pipe <= {fault_pipe[1:0], i_phy_fault};

	assign o_phy_fault = fault_pipe[2];

	// PHY fault wins over remote, remote over local
	always_comb
		if (o_phy_fault)
			o_lock = netdbg_pkg::LOCK_PHY;
		else if (i_remote_fault)
			o_lock = netdbg_pkg::LOCK_REMOTE;
		else if (i_local_fault)
			o_lock = netdbg_pkg::LOCK_LOCAL;
		else
			o_lock = netdbg_pkg::LOCK_OK;

	//////////////////////////////////////////////////////////////////////
	// Timestamp and wrap tick
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
		if (i_reset)
		begin
			o_time <= '0;
			o_tick <= 1'b0;
		end
		else
		begin
			o_time <= o_time + 1'b1;
			// Registered, so it lines up with the all-ones count
			o_tick <= (o_time == {{(netdbg_pkg::TIME_W-1){1'b1}}, 1'b0});
		end

	// Sync header of the live word, else the last one seen
	always_ff @(posedge i_clk)
		if (i_reset)
			last_sync <= '1;
		else if (i_p66b_valid)
			last_sync <= i_p66b_data;

	assign o_sync = i_p66b_valid ? i_p66b_data : last_sync;

	a_tick_at_max: assert property (@(posedge i_clk) disable iff (i_reset)
		o_tick |-> (o_time == '1));

endmodule

`default_nettype wire

// ==== source/netdbg_idle.sv ====
`timescale 1ns/1ps
`default_nettype none

module netdbg_idle (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_p66b_valid,
	input wire logic [netdbg_pkg::P66_W-1:0] i_p66b_data,
	input wire logic [netdbg_pkg::LOCK_W-1:0] i_lock,
	input wire logic i_phy_fault,
	input wire logic [netdbg_pkg::TIME_W-1:0] i_time,
	input wire logic i_tick,
	input wire logic [netdbg_pkg::SYNC_W-1:0] i_sync,
	input wire logic i_ready,
	output logic o_valid,
	output netdbg_pkg::dbg_word_u o_data
);

	logic [netdbg_pkg::LGIDLE:0] run_count;
	logic [netdbg_pkg::RPT_W-1:0] rpt_count;
	logic rpt_accept;
	logic report;
	logic load;

	assign rpt_accept = o_valid && i_ready;
	assign report = i_tick && run_count[netdbg_pkg::LGIDLE] && !i_phy_fault;
	assign load = report && (!o_valid || i_ready);

	// Any real traffic on a good link restarts the run
	always_ff @(posedge i_clk)
		if (i_reset)
			run_count <= '0;
		else if (i_p66b_valid && i_lock == netdbg_pkg::LOCK_OK
				&& i_p66b_data != netdbg_pkg::P_IDLE)
			run_count <= '0;
		else if (i_p66b_valid && !run_count[netdbg_pkg::LGIDLE])
			run_count <= run_count + 1'b1;

	always_ff @(posedge i_clk)
		if (i_reset)
			o_valid <= 1'b0;
		else if (report)
			o_valid <= 1'b1;
		else if (i_ready)
			o_valid <= 1'b0;

	// Reports taken by the arbiter so far
	always_ff @(posedge i_clk)
		if (i_reset)
			rpt_count <= '0;
		else if (rpt_accept)
			rpt_count <= rpt_count + 1'b1;

	always_ff @(posedge i_clk)
		if (load)
		begin
			o_data.idle_rec.lock <= i_lock;
			o_data.idle_rec.kind <= netdbg_pkg::KIND_IDLE;
			o_data.idle_rec.stamp <= i_time;
			// Count the report leaving in this same cycle too
			o_data.idle_rec.count <= rpt_count + netdbg_pkg::RPT_W'(rpt_accept);
			o_data.idle_rec.sync <= i_sync;
		end

endmodule

`default_nettype wire

// ==== source/netdbg_stat.sv ====
`timescale 1ns/1ps
`default_nettype none

module netdbg_stat #(
	parameter logic [netdbg_pkg::KIND_W-1:0] P_KIND = netdbg_pkg::KIND_RX
) (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic i_packet,
	input wire logic [netdbg_pkg::PKTLEN_W-1:0] i_pktlen,
	input wire logic [netdbg_pkg::LOCK_W-1:0] i_lock,
	input wire logic [netdbg_pkg::TIME_W-1:0] i_time,
	input wire logic [netdbg_pkg::SYNC_W-1:0] i_sync,
	input wire logic i_ready,
	output logic o_valid,
	output netdbg_pkg::dbg_word_u o_data
);

	logic slot_free;
	logic capture;

	// Empty now, or emptied by the arbiter this cycle
	assign slot_free = !o_valid || i_ready;
	assign capture = i_packet && slot_free;

	//////////////////////////////////////////////////////////////////////
	// Slot occupancy
	//////////////////////////////////////////////////////////////////////
	// A pulse into a full, stalled slot keeps it full
	always_ff @(posedge i_clk)
		if (i_reset)
			o_valid <= 1'b0;
		else if (i_packet)
			o_valid <= 1'b1;
		else if (i_ready)
			o_valid <= 1'b0;

	//////////////////////////////////////////////////////////////////////
	// Record capture
	//////////////////////////////////////////////////////////////////////
	// Held record is never overwritten, the new event is lost
	always_ff @(posedge i_clk)
		if (capture)
		begin
			o_data.stat_rec.lock <= i_lock;
			o_data.stat_rec.kind <= P_KIND;
			o_data.stat_rec.time_hi <= i_time[netdbg_pkg::TIME_W-1:2];
			o_data.stat_rec.pktlen <= i_pktlen;
			o_data.stat_rec.sync <= i_sync;
		end

	a_hold_data: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_valid && !i_ready) |=> $stable(o_data));

endmodule

`default_nettype wire

// ==== source/netdbg_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module netdbg_arbiter (
	input wire logic i_clk,
	input wire logic i_reset,
	input wire logic [netdbg_pkg::N_SRC-1:0] i_req,
	input wire logic [netdbg_pkg::N_SRC-1:0][netdbg_pkg::DBG_W-1:0] i_rec,
	input wire logic i_dbg_ready,
	output logic [netdbg_pkg::N_SRC-1:0] o_grant,
	output logic o_dbg_valid,
	output logic [netdbg_pkg::DBG_W-1:0] o_dbg_data
);

	logic [netdbg_pkg::SRC_IDX_W-1:0] last_idx;
	logic [netdbg_pkg::SRC_IDX_W-1:0] grant_idx;
	logic found;
	logic can_load;
	logic grant_any;

	// Output register is empty or draining this cycle
	assign can_load = !o_dbg_valid || i_dbg_ready;

	//////////////////////////////////////////////////////////////////////
	// Round-robin search
	//////////////////////////////////////////////////////////////////////
	// Starts one past the last winner and wraps around
	always_comb
	begin
		int idx;

		found = 1'b0;
		grant_idx = last_idx;
		for (int i = 1; i <= netdbg_pkg::N_SRC; i++)
		begin
			idx = int'(last_idx) + i;
			if (idx >= netdbg_pkg::N_SRC)
				idx = idx - netdbg_pkg::N_SRC;
			if (!found && i_req[idx])
			begin
				found = 1'b1;
				grant_idx = netdbg_pkg::SRC_IDX_W'(idx);
			end
		end
	end

	assign grant_any = found && can_load;

	always_comb
	begin
		o_grant = '0;
		if (grant_any)
			o_grant[grant_idx] = 1'b1;
	end

	// Idle source gets first pick after reset
	always_ff @(posedge i_clk)
		if (i_reset)
			last_idx <= netdbg_pkg::SRC_IDX_W'(netdbg_pkg::N_SRC - 1);
		else if (grant_any)
			last_idx <= grant_idx;

	//////////////////////////////////////////////////////////////////////
	// Output stage
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
		if (i_reset)
			o_dbg_valid <= 1'b0;
		else if (can_load)
			o_dbg_valid <= grant_any;

	always_ff @(posedge i_clk)
		if (i_reset)
			o_dbg_data <= '0;
		else if (grant_any)
			o_dbg_data <= i_rec[grant_idx];

	a_grant_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
		$onehot0(o_grant));

	a_no_grant_stall: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_dbg_valid && !i_dbg_ready) |-> (o_grant == '0));

	a_stall_stable: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_dbg_valid && !i_dbg_ready) |=> $stable(o_dbg_data));

endmodule

`default_nettype wire

// ==== source/netdbggen.sv ====
`timescale 1ns/1ps
`default_nettype none

module netdbggen (
	input wire i_clk,
	input wire i_reset,
	input wire i_phy_fault,
	input wire i_remote_fault,
	input wire i_local_fault,
	// Link words, never stalled
	input wire i_p66b_valid,
	input wire [netdbg_pkg::P66_W-1:0] i_p66b_data,
	// Packet completion pulses
	input wire i_rx_packet,
	input wire [netdbg_pkg::PKTLEN_W-1:0] i_rx_pktlen,
	input wire i_crc_packet,
	input wire [netdbg_pkg::PKTLEN_W-1:0] i_crc_pktlen,
	input wire i_txgate_packet,
	input wire [netdbg_pkg::PKTLEN_W-1:0] i_txgate_pktlen,
	input wire i_tx_packet,
	input wire [netdbg_pkg::PKTLEN_W-1:0] i_tx_pktlen,
	// Debug record stream
	output wire o_dbg_valid,
	input wire i_dbg_ready,
	output wire [netdbg_pkg::DBG_W-1:0] o_dbg_data
);

	wire [netdbg_pkg::LOCK_W-1:0] lock;
	wire phy_fault;
	wire [netdbg_pkg::TIME_W-1:0] timestamp;
	wire tick;
	wire [netdbg_pkg::SYNC_W-1:0] sync;

	// Source order is idle, rx, crc, txgate, tx
	wire [netdbg_pkg::N_SRC-1:0] src_valid;
	wire [netdbg_pkg::N_SRC-1:0] src_ready;
	wire [netdbg_pkg::N_SRC-1:0][netdbg_pkg::DBG_W-1:0] src_rec;

	netdbg_status u_status (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_phy_fault(i_phy_fault),
		.i_remote_fault(i_remote_fault),
		.i_local_fault(i_local_fault),
		.i_p66b_valid(i_p66b_valid),
		.i_p66b_data(i_p66b_data[netdbg_pkg::SYNC_W-1:0]),
		.o_lock(lock), .o_phy_fault(phy_fault),
		.o_time(timestamp), .o_tick(tick), .o_sync(sync)
	);

	//////////////////////////////////////////////////////////////////////
	// Record sources
	//////////////////////////////////////////////////////////////////////
	netdbg_idle u_idle (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_p66b_valid(i_p66b_valid), .i_p66b_data(i_p66b_data),
		.i_lock(lock), .i_phy_fault(phy_fault),
		.i_time(timestamp), .i_tick(tick), .i_sync(sync),
		.i_ready(src_ready[0]),
		.o_valid(src_valid[0]), .o_data(src_rec[0])
	);

	netdbg_stat #(.P_KIND(netdbg_pkg::KIND_RX)) u_stat_rx (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_packet(i_rx_packet), .i_pktlen(i_rx_pktlen),
		.i_lock(lock), .i_time(timestamp), .i_sync(sync),
		.i_ready(src_ready[1]),
		.o_valid(src_valid[1]), .o_data(src_rec[1])
	);

	netdbg_stat #(.P_KIND(netdbg_pkg::KIND_CRC)) u_stat_crc (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_packet(i_crc_packet), .i_pktlen(i_crc_pktlen),
		.i_lock(lock), .i_time(timestamp), .i_sync(sync),
		.i_ready(src_ready[2]),
		.o_valid(src_valid[2]), .o_data(src_rec[2])
	);

	netdbg_stat #(.P_KIND(netdbg_pkg::KIND_TXGATE)) u_stat_txgate (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_packet(i_txgate_packet), .i_pktlen(i_txgate_pktlen),
		.i_lock(lock), .i_time(timestamp), .i_sync(sync),
		.i_ready(src_ready[3]),
		.o_valid(src_valid[3]), .o_data(src_rec[3])
	);

	netdbg_stat #(.P_KIND(netdbg_pkg::KIND_TX)) u_stat_tx (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_packet(i_tx_packet), .i_pktlen(i_tx_pktlen),
		.i_lock(lock), .i_time(timestamp), .i_sync(sync),
		.i_ready(src_ready[4]),
		.o_valid(src_valid[4]), .o_data(src_rec[4])
	);

	// Merge into the one registered output
	netdbg_arbiter u_arbiter (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_req(src_valid), .i_rec(src_rec),
		.i_dbg_ready(i_dbg_ready),
		.o_grant(src_ready),
		.o_dbg_valid(o_dbg_valid), .o_dbg_data(o_dbg_data)
	);

endmodule

`default_nettype wire

// ==== test/netdbg_model.svh ====
`ifndef NETDBG_MODEL_SVH
`define NETDBG_MODEL_SVH

// Reference state, source 0 is the idle report, then rx, crc, txgate, tx
logic [2:0] m_fault;
logic [netdbg_pkg::TIME_W-1:0] m_time;
logic [netdbg_pkg::SYNC_W-1:0] m_last_sync;
logic [netdbg_pkg::LGIDLE:0] m_run;
logic [15:0] m_rpt;
logic [netdbg_pkg::N_SRC-1:0] m_valid;
int m_last_idx;
logic m_out_valid;
logic m_any_loaded;
int drop_count;

// Expected records, one queue per source
logic [netdbg_pkg::DBG_W-1:0] exp_q[netdbg_pkg::N_SRC][$];

function automatic logic [netdbg_pkg::KIND_W-1:0] src_kind(input int src);
	case (src)
		0: return netdbg_pkg::KIND_IDLE;
		1: return netdbg_pkg::KIND_RX;
		2: return netdbg_pkg::KIND_CRC;
		3: return netdbg_pkg::KIND_TXGATE;
		default: return netdbg_pkg::KIND_TX;
	endcase
endfunction

function automatic int kind_src(input logic [netdbg_pkg::KIND_W-1:0] kind);
	for (int s = 0; s < netdbg_pkg::N_SRC; s++)
		if (src_kind(s) == kind)
			return s;
	return -1;
endfunction

task automatic model_reset();
	m_fault = '1;
	m_time = '0;
	m_last_sync = '1;
	m_run = '0;
	m_rpt = '0;
	m_valid = '0;
	m_last_idx = netdbg_pkg::N_SRC - 1;
	m_out_valid = 1'b0;
	m_any_loaded = 1'b0;
	drop_count = 0;
endtask

// One clock edge, using the inputs that the DUT samples at that edge
task automatic model_step();
	logic [netdbg_pkg::LOCK_W-1:0] lock;
	logic [netdbg_pkg::SYNC_W-1:0] sync;
	logic [netdbg_pkg::N_SRC-1:0] pkt;
	logic [netdbg_pkg::N_SRC-1:0] grant;
	logic [netdbg_pkg::PKTLEN_W-1:0] len [netdbg_pkg::N_SRC];
	logic report;
	logic can_load;
	int pick;

	if (m_fault[2])
		lock = netdbg_pkg::LOCK_PHY;
	else if (i_remote_fault)
		lock = netdbg_pkg::LOCK_REMOTE;
	else if (i_local_fault)
		lock = netdbg_pkg::LOCK_LOCAL;
	else
		lock = netdbg_pkg::LOCK_OK;
	sync = i_p66b_valid ? i_p66b_data[1:0] : m_last_sync;
	pkt = {i_tx_packet, i_txgate_packet, i_crc_packet, i_rx_packet, 1'b0};
	len = '{'0, i_rx_pktlen, i_crc_pktlen, i_txgate_pktlen, i_tx_pktlen};

	// First full slot after the last winner
	pick = -1;
	for (int i = 1; i <= netdbg_pkg::N_SRC; i++)
		if (pick < 0 && m_valid[(m_last_idx + i) % netdbg_pkg::N_SRC])
			pick = (m_last_idx + i) % netdbg_pkg::N_SRC;
	can_load = !m_out_valid || i_dbg_ready;
	grant = '0;
	if (pick >= 0 && can_load)
		grant[pick] = 1'b1;

	for (int s = 1; s < netdbg_pkg::N_SRC; s++)
	begin
		if (pkt[s] && (!m_valid[s] || grant[s]))
			exp_q[s].push_back({lock, src_kind(s), m_time[7:2], len[s], sync});
		else if (pkt[s])
			drop_count++;
		if (pkt[s])
			m_valid[s] = 1'b1;
		else if (grant[s])
			m_valid[s] = 1'b0;
	end

	// Idle report at the wrap, once the run has saturated
	report = (m_time == 8'hff) && m_run[netdbg_pkg::LGIDLE] && !m_fault[2];
	if (report && (!m_valid[0] || grant[0]))
		exp_q[0].push_back({lock, netdbg_pkg::KIND_IDLE, m_time, m_rpt + 16'(grant[0]), sync});
	m_rpt = m_rpt + 16'(grant[0]);
	if (report)
		m_valid[0] = 1'b1;
	else if (grant[0])
		m_valid[0] = 1'b0;
	if (i_p66b_valid && lock == netdbg_pkg::LOCK_OK && i_p66b_data != netdbg_pkg::P_IDLE)
		m_run = '0;
	else if (i_p66b_valid && !m_run[netdbg_pkg::LGIDLE])
		m_run = m_run + 1'b1;

	if (can_load)
		m_out_valid = (pick >= 0);
	if (grant != '0)
	begin
		m_last_idx = pick;
		m_any_loaded = 1'b1;
	end
	m_time = m_time + 1'b1;
	if (i_p66b_valid)
		m_last_sync = i_p66b_data[1:0];
	m_fault = {m_fault[1:0], i_phy_fault};
endtask

`endif

// ==== test/tb_netdbggen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_netdbggen;

	localparam int CLK_PERIOD = 40;
	localparam int PH_MIXED = 0;
	localparam int PH_IDLE = 1;
	localparam int PH_PHY = 2;
	localparam int PH_REMOTE = 3;
	localparam int PH_DRAIN = 4;
	localparam int MIXED_CYCLES = 2000;
	localparam int IDLE_CYCLES = 6000;
	localparam int FAULT_CYCLES = 1200;
	localparam int TEST_CYCLES = 4 + MIXED_CYCLES + IDLE_CYCLES + 2 * FAULT_CYCLES;
	// Extra cycles cover the drain at the end
	localparam int TIMEOUT_NS = (TEST_CYCLES + 1000) * CLK_PERIOD;

	logic i_clk;
	logic i_reset;
	logic i_phy_fault;
	logic i_remote_fault;
	logic i_local_fault;
	logic i_p66b_valid;
	logic [netdbg_pkg::P66_W-1:0] i_p66b_data;
	logic i_rx_packet;
	logic [netdbg_pkg::PKTLEN_W-1:0] i_rx_pktlen;
	logic i_crc_packet;
	logic [netdbg_pkg::PKTLEN_W-1:0] i_crc_pktlen;
	logic i_txgate_packet;
	logic [netdbg_pkg::PKTLEN_W-1:0] i_txgate_pktlen;
	logic i_tx_packet;
	logic [netdbg_pkg::PKTLEN_W-1:0] i_tx_pktlen;
	logic i_dbg_ready;
	wire o_dbg_valid;
	wire [netdbg_pkg::DBG_W-1:0] o_dbg_data;

	int idle_seen;
	int stat_seen;
	logic stalled;
	logic [netdbg_pkg::DBG_W-1:0] stall_data;

	`include "netdbg_model.svh"

	netdbggen dut (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_phy_fault(i_phy_fault), .i_remote_fault(i_remote_fault),
		.i_local_fault(i_local_fault),
		.i_p66b_valid(i_p66b_valid), .i_p66b_data(i_p66b_data),
		.i_rx_packet(i_rx_packet), .i_rx_pktlen(i_rx_pktlen),
		.i_crc_packet(i_crc_packet), .i_crc_pktlen(i_crc_pktlen),
		.i_txgate_packet(i_txgate_packet), .i_txgate_pktlen(i_txgate_pktlen),
		.i_tx_packet(i_tx_packet), .i_tx_pktlen(i_tx_pktlen),
		.o_dbg_valid(o_dbg_valid), .i_dbg_ready(i_dbg_ready),
		.o_dbg_data(o_dbg_data)
	);

	task automatic check(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected)
		begin
			$display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, actual, expected);
			$display("Simulation FAILED");
			$fatal(1, "stopping at first error");
		end
	endtask

	function automatic int records_pending();
		int total;

		total = $countones(m_valid) + int'(o_dbg_valid);
		for (int s = 0; s < netdbg_pkg::N_SRC; s++)
			total += exp_q[s].size();
		return total;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////
	task automatic drive_inputs(input int phase);
		logic [95:0] rand_word;
		int pkt_range;

		rand_word = {$urandom, $urandom, $urandom};
		pkt_range = (phase == PH_MIXED) ? 3 : 15;
		i_rx_packet = (phase != PH_DRAIN) && ($urandom_range(pkt_range, 0) == 0);
		i_crc_packet = (phase != PH_DRAIN) && ($urandom_range(pkt_range, 0) == 0);
		i_txgate_packet = (phase != PH_DRAIN) && ($urandom_range(pkt_range, 0) == 0);
		i_tx_packet = (phase != PH_DRAIN) && ($urandom_range(pkt_range, 0) == 0);
		i_rx_pktlen = rand_word[17:0];
		i_crc_pktlen = rand_word[35:18];
		i_txgate_pktlen = rand_word[53:36];
		i_tx_pktlen = rand_word[71:54];
		if (phase == PH_MIXED)
			i_dbg_ready = ($urandom_range(1, 0) == 0);
		else
			i_dbg_ready = (phase == PH_DRAIN) || ($urandom_range(3, 0) != 0);

		// Mostly legal sync headers, now and then a bad one
		rand_word = {$urandom, $urandom, $urandom};
		i_p66b_data = rand_word[65:0];
		if ($urandom_range(7, 0) != 0)
			i_p66b_data[1:0] = rand_word[70] ? netdbg_pkg::SYNC_DATA : netdbg_pkg::SYNC_CONTROL;
		case (phase)
			PH_MIXED:
			begin
				if ($urandom_range(63, 0) == 0)
				begin
					i_phy_fault = ($urandom_range(7, 0) == 0);
					i_remote_fault = ($urandom_range(3, 0) == 0);
					i_local_fault = ($urandom_range(3, 0) == 0);
				end
				i_p66b_valid = rand_word[80];
				if (rand_word[81])
					i_p66b_data = netdbg_pkg::P_IDLE;
			end
			PH_IDLE:
			begin
				{i_phy_fault, i_remote_fault, i_local_fault} = 3'b000;
				i_p66b_valid = ($urandom_range(15, 0) != 0);
				i_p66b_data = netdbg_pkg::P_IDLE;
			end
			PH_PHY:
			begin
				// Quiet link keeps the run saturated under the fault
				{i_phy_fault, i_remote_fault, i_local_fault} = 3'b100;
				i_p66b_valid = 1'b1;
				i_p66b_data = netdbg_pkg::P_IDLE;
			end
			PH_REMOTE:
			begin
				{i_phy_fault, i_remote_fault, i_local_fault} = 3'b010;
				i_p66b_valid = ($urandom_range(3, 0) != 0);
			end
			default:
			begin
				// PHY fault holds off new idle reports while draining
				{i_phy_fault, i_remote_fault, i_local_fault} = 3'b100;
				i_p66b_valid = 1'b0;
			end
		endcase
	endtask

	task automatic run_phase(input int phase, input int cycles);
		repeat (cycles)
		begin
			@(posedge i_clk);
			#2;
			drive_inputs(phase);
		end
	endtask

	initial
	begin
		i_clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////////////////////////////////////////////
	// Output checking, sampled on the falling edge
	//////////////////////////////////////////////////////////////////////
	always @(negedge i_clk)
	begin : output_monitor
		netdbg_pkg::dbg_word_u rec;
		int src;

		if (i_reset)
		begin
			check(o_dbg_valid, 0, "output valid low in reset");
			check(o_dbg_data, 0, "output data zero in reset");
			stalled = 1'b0;
			model_reset();
		end
		else
		begin
			check(o_dbg_valid, m_out_valid, "output valid");
			if (!m_any_loaded)
				check(o_dbg_data, 0, "output data zero before the first record");
			if (stalled)
				check(o_dbg_data, stall_data, "output data held under back-pressure");
			stalled = o_dbg_valid && !i_dbg_ready;
			stall_data = o_dbg_data;
			if (o_dbg_valid && i_dbg_ready)
			begin
				rec = o_dbg_data;
				src = kind_src(rec.stat_rec.kind);
				check(src >= 0, 1, "record kind is a known one");
				if (src >= 0)
				begin
					check(exp_q[src].size() > 0, 1,
						$sformatf("a kind %0d record was expected", rec.stat_rec.kind));
					if (exp_q[src].size() > 0)
						check(o_dbg_data, exp_q[src].pop_front(),
							$sformatf("kind %0d record contents", rec.stat_rec.kind));
					if (src == 0)
						idle_seen++;
					else
						stat_seen++;
				end
			end
			model_step();
		end
	end

	initial
	begin
		void'($urandom(32'h6160_a978));
		i_reset = 1'b1;
		{i_phy_fault, i_remote_fault, i_local_fault} = 3'b000;
		i_p66b_valid = 1'b0;
		i_p66b_data = '0;
		{i_rx_packet, i_crc_packet, i_txgate_packet, i_tx_packet} = 4'b0000;
		i_rx_pktlen = '0;
		i_crc_pktlen = '0;
		i_txgate_pktlen = '0;
		i_tx_pktlen = '0;
		i_dbg_ready = 1'b0;
		idle_seen = 0;
		stat_seen = 0;
		stalled = 1'b0;
		stall_data = '0;
		repeat (4) @(posedge i_clk);
		#2;
		i_reset = 1'b0;

		run_phase(PH_MIXED, MIXED_CYCLES);
		run_phase(PH_IDLE, IDLE_CYCLES);
		run_phase(PH_PHY, FAULT_CYCLES);
		run_phase(PH_REMOTE, FAULT_CYCLES);
		run_phase(PH_DRAIN, 8);
		while (records_pending() != 0)
			run_phase(PH_DRAIN, 1);
		run_phase(PH_DRAIN, 4);

		check(records_pending(), 0, "all expected records delivered");
		check(idle_seen >= 2, 1, "idle reports seen");
		check(stat_seen >= 500, 1, "packet records seen");
		check(drop_count > 0, 1, "packet events lost on a busy slot");
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+test
source/netdbg_pkg.sv
source/netdbg_status.sv
source/netdbg_idle.sv
source/netdbg_stat.sv
source/netdbg_arbiter.sv
source/netdbggen.sv
test/tb_netdbggen.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_netdbggen \
	-f flist.f -o tb_netdbggen \
	&& ./obj_dir/tb_netdbggen 2>&1 | tee sim.log \
	|| echo "Verilator build or run error"
grep -q "Simulation PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
